// ==== rtl/rv_pkg.sv ====
package rv_pkg;

    // ------------------------------
    // Widths.
    // ------------------------------
    localparam int XLEN    = 64;
    localparam int INSTR_W = 32;
    localparam int REG_AW  = 5;

    // Fetch increment.
    localparam logic [XLEN-1:0] PC_STEP = XLEN'(4);

    // One instruction word, seen through each encoding format.
    typedef union packed {
        struct packed {
            logic [6:0]        funct7;
            logic [REG_AW-1:0] rs2;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } r;
        struct packed {
            logic [11:0]       imm;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } i;
        struct packed {
            logic [6:0]        imm_hi;
            logic [REG_AW-1:0] rs2;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [4:0]        imm_lo;
            logic [6:0]        opcode;
        } s;
        struct packed {
            logic              imm_12;
            logic [5:0]        imm_10_5;
            logic [REG_AW-1:0] rs2;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [3:0]        imm_4_1;
            logic              imm_11;
            logic [6:0]        opcode;
        } b;
        struct packed {
            logic [19:0]       imm;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } u;
        struct packed {
            logic              imm_20;
            logic [9:0]        imm_10_1;
            logic              imm_11;
            logic [7:0]        imm_19_12;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } j;
    } instr_t;

    // ------------------------------
    // Opcodes.
    // ------------------------------
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // ------------------------------
    // ALU operations.
    // ------------------------------
    localparam logic [3:0] ALU_ADD  = 4'd0;
    localparam logic [3:0] ALU_SUB  = 4'd1;
    localparam logic [3:0] ALU_AND  = 4'd2;
    localparam logic [3:0] ALU_OR   = 4'd3;
    localparam logic [3:0] ALU_XOR  = 4'd4;
    localparam logic [3:0] ALU_SLL  = 4'd5;
    localparam logic [3:0] ALU_SRL  = 4'd6;
    localparam logic [3:0] ALU_SRA  = 4'd7;
    localparam logic [3:0] ALU_SLT  = 4'd8;
    localparam logic [3:0] ALU_SLTU = 4'd9;

    // Source and result multiplexer selects.
    localparam logic [1:0] SRC_A_PC     = 2'd0;
    localparam logic [1:0] SRC_A_OLD_PC = 2'd1;
    localparam logic [1:0] SRC_A_REG    = 2'd2;

    localparam logic [1:0] SRC_B_REG  = 2'd0;
    localparam logic [1:0] SRC_B_IMM  = 2'd1;
    localparam logic [1:0] SRC_B_STEP = 2'd2;

    localparam logic [1:0] RES_ALU  = 2'd0;
    localparam logic [1:0] RES_MDR  = 2'd1;
    localparam logic [1:0] RES_IMM  = 2'd2;
    localparam logic [1:0] RES_LINK = 2'd3;

    // Immediate formats.
    localparam logic [2:0] IMM_I = 3'd0;
    localparam logic [2:0] IMM_S = 3'd1;
    localparam logic [2:0] IMM_B = 3'd2;
    localparam logic [2:0] IMM_U = 3'd3;
    localparam logic [2:0] IMM_J = 3'd4;

endpackage

// ==== rtl/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
    input  logic [3:0]              i_op,
    input  logic [rv_pkg::XLEN-1:0] i_a,
    input  logic [rv_pkg::XLEN-1:0] i_b,
    output logic [rv_pkg::XLEN-1:0] o_result,
    output logic                    o_zero,
    output logic                    o_lt,
    output logic                    o_ltu
);
    import rv_pkg::*;

    logic [5:0] s_shamt;

    // RV64 shifts use the low six bits.
    assign s_shamt = i_b[5:0];

    // Compare flags do not depend on the selected operation.
    assign o_lt   = $signed(i_a) < $signed(i_b);
    assign o_ltu  = i_a < i_b;
    assign o_zero = (o_result == '0);

    always_comb begin
        case (i_op)
            ALU_ADD:  o_result = i_a + i_b;
            ALU_SUB:  o_result = i_a - i_b;
            ALU_AND:  o_result = i_a & i_b;
            ALU_OR:   o_result = i_a | i_b;
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_SLL:  o_result = i_a << s_shamt;
            ALU_SRL:  o_result = i_a >> s_shamt;
            ALU_SRA:  o_result = $signed(i_a) >>> s_shamt;
            ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, o_lt};
            ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, o_ltu};
            default:  o_result = '0;
        endcase
    end

endmodule

// ==== rtl/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_we,
    input  logic [rv_pkg::REG_AW-1:0] i_raddr1,
    input  logic [rv_pkg::REG_AW-1:0] i_raddr2,
    input  logic [rv_pkg::REG_AW-1:0] i_waddr,
    input  logic [rv_pkg::XLEN-1:0]   i_wdata,
    output logic [rv_pkg::XLEN-1:0]   o_rdata1,
    output logic [rv_pkg::XLEN-1:0]   o_rdata2
);
    import rv_pkg::*;

    logic [XLEN-1:0] s_regs [2**REG_AW];

    // x0 is cleared by reset and never written.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                s_regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            s_regs[i_waddr] <= i_wdata;
        end
    end

    // Asynchronous read ports.
    assign o_rdata1 = s_regs[i_raddr1];
    assign o_rdata2 = s_regs[i_raddr2];

endmodule

// ==== rtl/rv_imm_ext.sv ====
`timescale 1ns/1ps

module rv_imm_ext (
    input  rv_pkg::instr_t          i_instr,
    input  logic [2:0]              i_sel,
    output logic [rv_pkg::XLEN-1:0] o_imm
);
    import rv_pkg::*;

    always_comb begin
        case (i_sel)
            IMM_S: o_imm = {{(XLEN-12){i_instr.s.imm_hi[6]}},
                            i_instr.s.imm_hi, i_instr.s.imm_lo};
            IMM_B: o_imm = {{(XLEN-12){i_instr.b.imm_12}}, i_instr.b.imm_11,
                            i_instr.b.imm_10_5, i_instr.b.imm_4_1, 1'b0};
            // Bit 31 of the upper immediate fills the top word.
            IMM_U: o_imm = {{(XLEN-32){i_instr.u.imm[19]}}, i_instr.u.imm, 12'b0};
            IMM_J: o_imm = {{(XLEN-20){i_instr.j.imm_20}}, i_instr.j.imm_19_12,
                            i_instr.j.imm_11, i_instr.j.imm_10_1, 1'b0};
            default: o_imm = {{(XLEN-12){i_instr.i.imm[11]}}, i_instr.i.imm};
        endcase
    end

endmodule

// ==== rtl/rv_control.sv ====
`timescale 1ns/1ps

module rv_control (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  rv_pkg::instr_t i_instr,
    input  logic           i_zero,
    input  logic           i_lt,
    input  logic           i_ltu,
    input  logic           i_mem_done,
    output logic           o_mem_start,
    output logic           o_mem_we,
    output logic           o_pc_we,
    output logic           o_instr_we,
    output logic           o_mdr_we,
    output logic           o_reg_we,
    output logic           o_addr_sel,
    output logic           o_pc_sel,
    output logic [1:0]     o_src_a_sel,
    output logic [1:0]     o_src_b_sel,
    output logic [1:0]     o_res_sel,
    output logic [3:0]     o_alu_op,
    output logic [2:0]     o_imm_sel
);
    import rv_pkg::*;

    localparam logic [2:0] S_FETCH   = 3'd0;
    localparam logic [2:0] S_DECODE  = 3'd1;
    localparam logic [2:0] S_EXECUTE = 3'd2;
    localparam logic [2:0] S_MEM     = 3'd3;
    localparam logic [2:0] S_WB      = 3'd4;

    logic [2:0] s_state;
    logic [2:0] s_next;
    logic       s_busy;
    logic       s_mem_next;
    logic       s_launch;
    logic       s_taken;
    logic       s_alt;
    logic [3:0] s_funct_op;
    logic [6:0] s_opcode;
    logic [2:0] s_funct3;

    assign s_opcode = i_instr.r.opcode;
    assign s_funct3 = i_instr.r.funct3;

    // ------------------------------
    // State and memory handshake.
    // ------------------------------

    // A new access starts on entry to a memory state, or once after reset.
    assign s_mem_next = (s_next == S_FETCH) || (s_next == S_MEM);
    assign s_launch   = s_mem_next && ((s_next != s_state) || (!s_busy && !o_mem_start));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s_state     <= S_FETCH;
            s_busy      <= 1'b0;
            o_mem_start <= 1'b0;
        end else begin
            s_state     <= s_next;
            o_mem_start <= s_launch;
            if (o_mem_start) begin
                s_busy <= 1'b1;
            end else if (i_mem_done) begin
                s_busy <= 1'b0;
            end
        end
    end

    always_comb begin
        s_next = s_state;
        case (s_state)
            S_FETCH: begin
                if (i_mem_done) begin
                    s_next = S_DECODE;
                end
            end
            S_DECODE: s_next = S_EXECUTE;
            S_EXECUTE: begin
                case (s_opcode)
                    OP_LOAD, OP_STORE: s_next = S_MEM;
                    OP_BRANCH:         s_next = S_FETCH;
                    default:           s_next = S_WB;
                endcase
            end
            S_MEM: begin
                if (i_mem_done) begin
                    s_next = (s_opcode == OP_LOAD) ? S_WB : S_FETCH;
                end
            end
            default: s_next = S_FETCH;
        endcase
    end

    // ------------------------------
    // Decode.
    // ------------------------------

    // Bit 30 picks SUB and SRA; for immediates only the shift uses it.
    assign s_alt = i_instr.r.funct7[5] && ((s_opcode == OP_R) || (s_funct3 == 3'b101));

    always_comb begin
        case (s_funct3)
            3'b000:  s_funct_op = s_alt ? ALU_SUB : ALU_ADD;
            3'b001:  s_funct_op = ALU_SLL;
            3'b010:  s_funct_op = ALU_SLT;
            3'b011:  s_funct_op = ALU_SLTU;
            3'b100:  s_funct_op = ALU_XOR;
            3'b101:  s_funct_op = s_alt ? ALU_SRA : ALU_SRL;
            3'b110:  s_funct_op = ALU_OR;
            default: s_funct_op = ALU_AND;
        endcase
    end

    // Branch condition from the compare flags.
    always_comb begin
        case (s_funct3)
            3'b000:  s_taken = i_zero;
            3'b001:  s_taken = !i_zero;
            3'b100:  s_taken = i_lt;
            3'b101:  s_taken = !i_lt;
            3'b110:  s_taken = i_ltu;
            3'b111:  s_taken = !i_ltu;
            default: s_taken = 1'b0;
        endcase
    end

    always_comb begin
        case (s_opcode)
            OP_STORE:  o_imm_sel = IMM_S;
            OP_BRANCH: o_imm_sel = IMM_B;
            OP_LUI:    o_imm_sel = IMM_U;
            OP_JAL:    o_imm_sel = IMM_J;
            default:   o_imm_sel = IMM_I;
        endcase
        case (s_opcode)
            OP_LOAD: o_res_sel = RES_MDR;
            OP_LUI:  o_res_sel = RES_IMM;
            OP_JAL:  o_res_sel = RES_LINK;
            default: o_res_sel = RES_ALU;
        endcase
    end

    // ------------------------------
    // Datapath controls.
    // ------------------------------
    assign o_mem_we   = (s_state == S_MEM) && (s_opcode == OP_STORE);
    assign o_addr_sel = (s_state == S_MEM);
    assign o_reg_we   = (s_state == S_WB);

    always_comb begin
        o_pc_we     = 1'b0;
        o_instr_we  = 1'b0;
        o_mdr_we    = 1'b0;
        o_pc_sel    = 1'b0;
        // Default is PC plus 4 for the fetch.
        o_src_a_sel = SRC_A_PC;
        o_src_b_sel = SRC_B_STEP;
        o_alu_op    = ALU_ADD;
        case (s_state)
            S_FETCH: begin
                o_instr_we = 1'b1;
                o_pc_we    = i_mem_done;
            end
            S_DECODE: begin
                // Branch or jump target into the ALU-result register.
                o_src_a_sel = SRC_A_OLD_PC;
                o_src_b_sel = SRC_B_IMM;
            end
            S_EXECUTE, S_MEM: begin
                // MEM repeats the address sum so the address holds.
                o_src_a_sel = SRC_A_REG;
                o_src_b_sel = SRC_B_IMM;
                o_pc_sel    = 1'b1;
                case (s_opcode)
                    OP_R: begin
                        o_src_b_sel = SRC_B_REG;
                        o_alu_op    = s_funct_op;
                    end
                    OP_IMM:    o_alu_op = s_funct_op;
                    OP_LOAD:   o_mdr_we = (s_state == S_MEM);
                    OP_BRANCH: begin
                        o_src_b_sel = SRC_B_REG;
                        o_alu_op    = ALU_SUB;
                        o_pc_we     = s_taken;
                    end
                    OP_JAL:    o_pc_we = 1'b1;
                    default:   o_alu_op = ALU_ADD;
                endcase
            end
            default: o_alu_op = ALU_ADD;
        endcase
    end

endmodule

// ==== rtl/rv_datapath.sv ====
`timescale 1ns/1ps

module rv_datapath #(
    parameter int ADDR_WIDTH = 16
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_pc_we,
    input  logic                    i_instr_we,
    input  logic                    i_mdr_we,
    input  logic                    i_reg_we,
    input  logic                    i_addr_sel,
    input  logic                    i_pc_sel,
    input  logic [1:0]              i_src_a_sel,
    input  logic [1:0]              i_src_b_sel,
    input  logic [1:0]              i_res_sel,
    input  logic [3:0]              i_alu_op,
    input  logic [2:0]              i_imm_sel,
    input  logic [rv_pkg::XLEN-1:0] i_mem_rdata,
    input  logic                    i_mem_done,
    output rv_pkg::instr_t          o_instr,
    output logic                    o_zero,
    output logic                    o_lt,
    output logic                    o_ltu,
    output logic [ADDR_WIDTH-1:0]   o_mem_addr,
    output logic [rv_pkg::XLEN-1:0] o_mem_wdata
);
    import rv_pkg::*;

    logic [ADDR_WIDTH-1:0] s_reg_pc;
    logic [ADDR_WIDTH-1:0] s_reg_old_pc;
    logic [ADDR_WIDTH-1:0] s_pc_next;
    logic [ADDR_WIDTH-1:0] s_link;
    logic [INSTR_W-1:0]    s_fetch_word;
    logic [XLEN-1:0]       s_rdata1;
    logic [XLEN-1:0]       s_rdata2;
    logic [XLEN-1:0]       s_reg_a;
    logic [XLEN-1:0]       s_reg_b;
    logic [XLEN-1:0]       s_reg_alu;
    logic [XLEN-1:0]       s_reg_mdr;
    logic [XLEN-1:0]       s_imm;
    logic [XLEN-1:0]       s_src_a;
    logic [XLEN-1:0]       s_src_b;
    logic [XLEN-1:0]       s_alu_result;
    logic [XLEN-1:0]       s_result;

    // The doubleword holds two instructions; PC bit 2 picks one.
    assign s_fetch_word = s_reg_pc[2] ? i_mem_rdata[2*INSTR_W-1:INSTR_W]
                                      : i_mem_rdata[INSTR_W-1:0];

    // ------------------------------
    // Registers.
    // ------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s_reg_pc <= '0;
            o_instr  <= '0;
        end else begin
            if (i_pc_we) begin
                s_reg_pc <= s_pc_next;
            end
            if (i_instr_we && i_mem_done) begin
                o_instr <= s_fetch_word;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        s_reg_a   <= s_rdata1;
        s_reg_b   <= s_rdata2;
        s_reg_alu <= s_alu_result;
        if (i_instr_we && i_mem_done) begin
            s_reg_old_pc <= s_reg_pc;
        end
        if (i_mdr_we && i_mem_done) begin
            s_reg_mdr <= i_mem_rdata;
        end
    end

    // ------------------------------
    // Multiplexers.
    // ------------------------------
    always_comb begin
        case (i_src_a_sel)
            SRC_A_PC:     s_src_a = XLEN'(s_reg_pc);
            SRC_A_OLD_PC: s_src_a = XLEN'(s_reg_old_pc);
            default:      s_src_a = s_reg_a;
        endcase
        case (i_src_b_sel)
            SRC_B_REG: s_src_b = s_reg_b;
            SRC_B_IMM: s_src_b = s_imm;
            default:   s_src_b = PC_STEP;
        endcase
        case (i_res_sel)
            RES_MDR:  s_result = s_reg_mdr;
            RES_IMM:  s_result = s_imm;
            RES_LINK: s_result = XLEN'(s_link);
            default:  s_result = s_reg_alu;
        endcase
    end

    // Return address for JAL.
    assign s_link = s_reg_old_pc + ADDR_WIDTH'(PC_STEP);

    // Fetch takes the live sum, jumps take the registered target.
    assign s_pc_next   = i_pc_sel ? s_reg_alu[ADDR_WIDTH-1:0] : s_alu_result[ADDR_WIDTH-1:0];
    assign o_mem_addr  = i_addr_sel ? s_reg_alu[ADDR_WIDTH-1:0] : s_reg_pc;
    assign o_mem_wdata = s_reg_b;

    rv_regfile i_regfile (
        .i_clk    ( i_clk         ),
        .i_rst_n  ( i_rst_n       ),
        .i_we     ( i_reg_we      ),
        .i_raddr1 ( o_instr.r.rs1 ),
        .i_raddr2 ( o_instr.r.rs2 ),
        .i_waddr  ( o_instr.r.rd  ),
        .i_wdata  ( s_result      ),
        .o_rdata1 ( s_rdata1      ),
        .o_rdata2 ( s_rdata2      )
    );

    rv_alu i_alu (
        .i_op     ( i_alu_op     ),
        .i_a      ( s_src_a      ),
        .i_b      ( s_src_b      ),
        .o_result ( s_alu_result ),
        .o_zero   ( o_zero       ),
        .o_lt     ( o_lt         ),
        .o_ltu    ( o_ltu        )
    );

    rv_imm_ext i_imm_ext (
        .i_instr ( o_instr   ),
        .i_sel   ( i_imm_sel ),
        .o_imm   ( s_imm     )
    );

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
    parameter int ADDR_WIDTH = 16
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_mem_done,
    input  logic [rv_pkg::XLEN-1:0] i_mem_rdata,
    output logic                    o_mem_start,
    output logic                    o_mem_we,
    output logic [ADDR_WIDTH-1:0]   o_mem_addr,
    output logic [rv_pkg::XLEN-1:0] o_mem_wdata
);
    import rv_pkg::*;

    // ------------------------------
    // Control to datapath.
    // ------------------------------
    instr_t     s_instr;
    logic       s_zero;
    logic       s_lt;
    logic       s_ltu;
    logic       s_pc_we;
    logic       s_instr_we;
    logic       s_mdr_we;
    logic       s_reg_we;
    logic       s_addr_sel;
    logic       s_pc_sel;
    logic [1:0] s_src_a_sel;
    logic [1:0] s_src_b_sel;
    logic [1:0] s_res_sel;
    logic [3:0] s_alu_op;
    logic [2:0] s_imm_sel;

    rv_control i_control (
        .i_clk       ( i_clk       ),
        .i_rst_n     ( i_rst_n     ),
        .i_instr     ( s_instr     ),
        .i_zero      ( s_zero      ),
        .i_lt        ( s_lt        ),
        .i_ltu       ( s_ltu       ),
        .i_mem_done  ( i_mem_done  ),
        .o_mem_start ( o_mem_start ),
        .o_mem_we    ( o_mem_we    ),
        .o_pc_we     ( s_pc_we     ),
        .o_instr_we  ( s_instr_we  ),
        .o_mdr_we    ( s_mdr_we    ),
        .o_reg_we    ( s_reg_we    ),
        .o_addr_sel  ( s_addr_sel  ),
        .o_pc_sel    ( s_pc_sel    ),
        .o_src_a_sel ( s_src_a_sel ),
        .o_src_b_sel ( s_src_b_sel ),
        .o_res_sel   ( s_res_sel   ),
        .o_alu_op    ( s_alu_op    ),
        .o_imm_sel   ( s_imm_sel   )
    );

    rv_datapath #(
        .ADDR_WIDTH ( ADDR_WIDTH )
    ) i_datapath (
        .i_clk       ( i_clk       ),
        .i_rst_n     ( i_rst_n     ),
        .i_pc_we     ( s_pc_we     ),
        .i_instr_we  ( s_instr_we  ),
        .i_mdr_we    ( s_mdr_we    ),
        .i_reg_we    ( s_reg_we    ),
        .i_addr_sel  ( s_addr_sel  ),
        .i_pc_sel    ( s_pc_sel    ),
        .i_src_a_sel ( s_src_a_sel ),
        .i_src_b_sel ( s_src_b_sel ),
        .i_res_sel   ( s_res_sel   ),
        .i_alu_op    ( s_alu_op    ),
        .i_imm_sel   ( s_imm_sel   ),
        .i_mem_rdata ( i_mem_rdata ),
        .i_mem_done  ( i_mem_done  ),
        .o_instr     ( s_instr     ),
        .o_zero      ( s_zero      ),
        .o_lt        ( s_lt        ),
        .o_ltu       ( s_ltu       ),
        .o_mem_addr  ( o_mem_addr  ),
        .o_mem_wdata ( o_mem_wdata )
    );

endmodule

// ==== verif/rv_checker.sv ====
`timescale 1ns/1ps

module rv_checker #(
    parameter int ADDR_WIDTH = 16
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_mem_start,
    input  logic                    i_mem_we,
    input  logic [ADDR_WIDTH-1:0]   i_mem_addr,
    input  logic [rv_pkg::XLEN-1:0] i_mem_wdata
);
    import rv_pkg::*;

    string                 test_name = "none";
    logic [ADDR_WIDTH-1:0] exp_addr [$];
    logic [XLEN-1:0]       exp_data [$];
    logic [ADDR_WIDTH-1:0] next_addr;
    logic [XLEN-1:0]       next_data;
    int                    expected_total = 0;
    int                    seen = 0;
    int                    test_errors = 0;
    int                    pass_count = 0;
    int                    fail_count = 0;
    int                    stray_count = 0;
    logic                  test_done = 1'b1;

    task automatic begin_test(input string name);
        test_name = name;
        exp_addr.delete();
        exp_data.delete();
        expected_total = 0;
        seen = 0;
        test_errors = 0;
        test_done = 1'b0;
    endtask

    task automatic expect_store(input logic [ADDR_WIDTH-1:0] addr, input logic [XLEN-1:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        expected_total++;
    endtask

    task automatic print_summary();
        $display("Summary: %0d tests passed, %0d failed, %0d stray stores",
                 pass_count, fail_count, stray_count);
    endtask

    // ------------------------------
    // Store strobe compare.
    // ------------------------------
    always @(posedge i_clk) begin
        if (i_rst_n && i_mem_start && i_mem_we) begin
            if (test_done || (exp_addr.size() == 0)) begin
                $display("Unexpected store to address %h in test %s", i_mem_addr, test_name);
                stray_count++;
            end else begin
                next_addr = exp_addr.pop_front();
                next_data = exp_data.pop_front();
                seen++;
                if ((next_addr !== i_mem_addr) || (next_data !== i_mem_wdata)) begin
                    $display("[ERROR] %s: store %0d expected addr %h data %h, actual addr %h data %h",
                             test_name, seen, next_addr, next_data, i_mem_addr, i_mem_wdata);
                    test_errors++;
                end
                if (seen == expected_total) begin
                    if (test_errors == 0) begin
                        $display("ok    %s: %0d stores matched", test_name, seen);
                        pass_count++;
                    end else begin
                        $display("fail  %s: %0d of %0d stores wrong", test_name, test_errors, seen);
                        fail_count++;
                    end
                    test_done = 1'b1;
                end
            end
        end
    end

endmodule

// ==== verif/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int ADDR_WIDTH = 16;
    localparam int MEM_WORDS  = 2**(ADDR_WIDTH-3);

    logic                  clk;
    logic                  rst_n;
    logic                  mem_done;
    logic [XLEN-1:0]       mem_rdata;
    logic                  mem_start;
    logic                  mem_we;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [XLEN-1:0]       mem_wdata;

    // Parsed test file.
    string                 test_names [$];
    int                    word_base [$];
    int                    word_num [$];
    logic [31:0]           prog_words [$];
    int                    store_base [$];
    int                    store_num [$];
    logic [ADDR_WIDTH-1:0] store_addr [$];
    logic [XLEN-1:0]       store_data [$];
    string                 cur_name = "none";
    int                    budget = 0;
    logic                  budget_ready = 1'b0;

    // Memory model state.
    logic [XLEN-1:0]       mem [MEM_WORDS];
    logic [31:0]           lfsr = 32'hfe63_7048;
    logic                  pending = 1'b0;
    int                    wait_cnt;
    logic                  req_we;
    logic [ADDR_WIDTH-4:0] req_idx;
    logic [XLEN-1:0]       req_wdata;
    logic                  bit0;
    logic                  bit1;

    rv_core #(
        .ADDR_WIDTH ( ADDR_WIDTH )
    ) i_rv_core (
        .i_clk       ( clk       ),
        .i_rst_n     ( rst_n     ),
        .i_mem_done  ( mem_done  ),
        .i_mem_rdata ( mem_rdata ),
        .o_mem_start ( mem_start ),
        .o_mem_we    ( mem_we    ),
        .o_mem_addr  ( mem_addr  ),
        .o_mem_wdata ( mem_wdata )
    );

    rv_checker #(
        .ADDR_WIDTH ( ADDR_WIDTH )
    ) i_checker (
        .i_clk       ( clk       ),
        .i_rst_n     ( rst_n     ),
        .i_mem_start ( mem_start ),
        .i_mem_we    ( mem_we    ),
        .i_mem_addr  ( mem_addr  ),
        .i_mem_wdata ( mem_wdata )
    );

    always #5 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // ------------------------------
    // Memory model.
    // ------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            pending = 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            if (pending) begin
                wait_cnt = wait_cnt - 1;
            end else if (mem_start) begin
                req_we    = mem_we;
                req_idx   = mem_addr[ADDR_WIDTH-1:3];
                req_wdata = mem_wdata;
                lfsr      = lfsr_next(lfsr);
                bit0      = lfsr[0];
                lfsr      = lfsr_next(lfsr);
                bit1      = lfsr[0];
                // Done comes 1 to 4 cycles after the start pulse.
                wait_cnt  = int'({bit1, bit0});
                pending   = 1'b1;
            end
            if (pending && (wait_cnt == 0)) begin
                pending = 1'b0;
                mem_done <= 1'b1;
                mem_rdata <= mem[req_idx];
                if (req_we) begin
                    mem[req_idx] = req_wdata;
                end
            end
        end
    end

    task automatic read_tests();
        int          fd;
        int          n;
        string       tok;
        string       rest;
        logic [31:0] word;
        logic [63:0] addr;
        logic [63:0] data;
        fd = $fopen("verif/rv_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verif/rv_tests.txt");
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
                n = $fgets(rest, fd);
            end else if (tok == "test") begin
                n = $fscanf(fd, "%s", tok);
                test_names.push_back(tok);
                word_base.push_back(prog_words.size());
                word_num.push_back(0);
                store_base.push_back(store_addr.size());
                store_num.push_back(0);
            end else if (tok == "s") begin
                n = $fscanf(fd, "%h %h", addr, data);
                store_addr.push_back(addr[ADDR_WIDTH-1:0]);
                store_data.push_back(data);
                store_num[store_num.size()-1]++;
            end else begin
                n = $sscanf(tok, "%h", word);
                prog_words.push_back(word);
                word_num[word_num.size()-1]++;
            end
        end
        $fclose(fd);
    endtask

    // Fill every doubleword from its index, then lay the program over it.
    task automatic load_test(input int t);
        logic [31:0] w;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {32'(i) ^ 32'h5a5a_5a5a, 32'(i) ^ 32'ha5a5_a5a5};
        end
        for (int k = 0; k < word_num[t]; k++) begin
            w = prog_words[word_base[t] + k];
            if (k % 2 == 1) begin
                mem[k/2][63:32] = w;
            end else begin
                mem[k/2][31:0] = w;
            end
        end
        i_checker.begin_test(test_names[t]);
        for (int k = 0; k < store_num[t]; k++) begin
            i_checker.expect_store(store_addr[store_base[t] + k], store_data[store_base[t] + k]);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        mem_done  = 1'b0;
        mem_rdata = '0;
        read_tests();
        budget = 200;
        foreach (word_num[t]) begin
            budget += 64 * word_num[t];
        end
        budget_ready = 1'b1;
        foreach (test_names[t]) begin
            @(posedge clk);
            rst_n <= 1'b0;
            cur_name = test_names[t];
            load_test(t);
            repeat (3) @(posedge clk);
            rst_n <= 1'b1;
            @(posedge clk);
            while (!i_checker.test_done) begin
                @(posedge clk);
            end
        end
        i_checker.print_summary();
        if ((test_names.size() > 0) && (i_checker.fail_count == 0) &&
            (i_checker.stray_count == 0) && (i_checker.pass_count == test_names.size())) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        wait (budget_ready);
        repeat (budget) @(posedge clk);
        $display("Timeout: test %s did not finish its stores within %0d cycles", cur_name, budget);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== verif/rv_tests.txt ====
# test <name>, then instruction words in hex loaded from address 0
# s <address> <doubleword> is one expected SD, in program order
test alu_rtype
40000513 00500093 ffd00113 402081b3 00353023 40110233 00453423 401152b3
00553823 00115333 00653c23 001123b3 00113433 02753023 02853423 0000006f
s 400 0000000000000008
s 408 fffffffffffffff8
s 410 ffffffffffffffff
s 418 07ffffffffffffff
s 420 0000000000000001
s 428 0000000000000000
test logic_imm
40000513 fff00093 80000137 12316193 0030c233 f001f293 02400393 00709333
00012413 fff1b493 007265b3 00327633 00253023 00453423 00553823 00653c23
02853023 02953423 02b53823 02c53c23 0000006f
s 400 ffffffff80000000
s 408 000000007ffffedc
s 410 ffffffff80000100
s 418 fffffff000000000
s 420 0000000000000001
s 428 0000000000000001
s 430 000000007ffffefc
s 438 0000000000000000
test load_store
40000513 123450b7 67808093 02000193 00309133 00116133 00253023 00053203
00453423 03700013 00053823 fff00293 fe553c23 0000006f
s 400 1234567812345678
s 408 1234567812345678
s 410 0000000000000000
s 3f8 ffffffffffffffff
test branch_jal
40000513 00300093 00000113 00110113 00253023 00850513 fe111ae3 00010463
008002ef 00153023 00553023 00110463 00153423 00253823 0000006f
s 400 0000000000000001
s 408 0000000000000002
s 410 0000000000000003
s 418 0000000000000024
s 428 0000000000000003

// ==== tb.f ====
rtl/rv_pkg.sv
rtl/rv_alu.sv
rtl/rv_regfile.sv
rtl/rv_imm_ext.sv
rtl/rv_control.sv
rtl/rv_datapath.sv
rtl/rv_core.sv
verif/rv_checker.sv
verif/tb_rv_core.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_rv_core -Mdir obj_dir -f tb.f
	@out="$$(./obj_dir/Vtb_rv_core)"; echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir
